/* src/icache_pkg.sv */
`default_nettype none

package icache_pkg;

    // byte address of one fetch
    typedef logic [31:0] addr_t;

    // one fetch word, two instructions wide
    typedef logic [63:0] fetch_data_t;

    // one beat on the refill bus
    typedef logic [31:0] bus_data_t;

    // log2 of beats per refill burst
    typedef logic [3:0] cbus_order_t;

    localparam int FETCH_BYTES = 8;
    localparam int BUS_BYTES   = 4;

    // fetch request from the front end
    typedef struct packed {
        logic  req;
        addr_t addr;
    } ibus_req_t;

    // fetch response, index says which 32-bit half was asked for
    typedef struct packed {
        logic        addr_ok;
        logic        data_ok;
        fetch_data_t data;
        logic        index;
    } ibus_resp_t;

    // refill burst request, addr is aligned to one beat
    typedef struct packed {
        logic        valid;
        addr_t       addr;
        cbus_order_t order;
    } cbus_req_t;

    // one refill beat
    typedef struct packed {
        logic      okay;
        logic      last;
        bus_data_t rdata;
    } cbus_resp_t;

endpackage

`default_nettype wire

/* src/plru_tree.sv */
`timescale 1ns/10ps
`default_nettype none

module plru_tree #(
    parameter int NUM_WAYS = 4,
    localparam int WAY_BITS = $clog2(NUM_WAYS)
) (
    input  wire logic [NUM_WAYS-2:0] select,
    input  wire logic [WAY_BITS-1:0] hit_way,
    output logic [WAY_BITS-1:0]      victim_way,
    output logic [NUM_WAYS-2:0]      new_select
);
    // node n has children 2n+1 and 2n+2, leaves follow the inner nodes
    int victim_node;

    // follow the selection bits down to a leaf
    always_comb begin
        int node;
        node = 0;
        for (int l = 0; l < WAY_BITS; l++) begin
            node = 2 * node + 1 + int'(select[node]);
        end
        victim_node = node - (NUM_WAYS - 1);
    end

    assign victim_way = WAY_BITS'(victim_node);

    // point every node on the hit path at the other subtree
    always_comb begin
        int node;
        int dir;
        new_select = select;
        node = 0;
        for (int l = 0; l < WAY_BITS; l++) begin
            dir = int'(hit_way[WAY_BITS-1-l]);
            new_select[node] = (dir == 0);
            node = 2 * node + 1 + dir;
        end
    end

    always_comb begin
        assert (victim_node >= 0 && victim_node < NUM_WAYS)
            else $error("plru victim %0d outside of %0d ways", victim_node, NUM_WAYS);
    end

endmodule

`default_nettype wire

/* src/beat_ready_mask.sv */
`timescale 1ns/10ps
`default_nettype none

module beat_ready_mask #(
    parameter int OFFSET_BITS    = 2,
    parameter int BEATS_PER_WORD = 2,
    localparam int NUM_WORDS = 2 ** OFFSET_BITS,
    localparam int NUM_BEATS = NUM_WORDS * BEATS_PER_WORD
) (
    input  wire logic [NUM_BEATS-1:0] marks,
    output logic [NUM_BEATS-1:0]      ready
);
    // running product inside each fetch word
    // a beat is ready once it and the lower beats of its word are in,
    // so the top beat of a word tells that the whole word is written
    always_comb begin
        logic run;
        int   i;
        run = 1'b1;
        i = 0;
        for (int w = 0; w < NUM_WORDS; w++) begin
            // restart at every word boundary
            run = 1'b1;
            for (int b = 0; b < BEATS_PER_WORD; b++) begin
                i = w * BEATS_PER_WORD + b;
                run = run & marks[i];
                ready[i] = run;
            end
        end
    end

endmodule

`default_nettype wire

/* src/line_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module line_ram #(
    parameter int NUM_WAYS    = 4,
    parameter int INDEX_BITS  = 2,
    parameter int OFFSET_BITS = 2,
    localparam int ADDR_BITS  = $clog2(NUM_WAYS) + INDEX_BITS + OFFSET_BITS,
    localparam int DEPTH      = 2 ** ADDR_BITS
) (
    input  wire logic                                 clk,
    input  wire logic [ADDR_BITS-1:0]                 rd_addr,
    output icache_pkg::fetch_data_t                   rd_data,
    input  wire logic [icache_pkg::FETCH_BYTES-1:0]   wr_en,
    input  wire logic [ADDR_BITS-1:0]                 wr_addr,
    input  wire icache_pkg::fetch_data_t              wr_data
);
    // one fetch word per entry, address is {way, index, offset}
    icache_pkg::fetch_data_t mem [DEPTH];

    // read port gives the old contents on a same-address write
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    // byte lanes let a beat fill one half of a word
    always_ff @(posedge clk) begin
        for (int b = 0; b < icache_pkg::FETCH_BYTES; b++) begin
            if (wr_en[b]) begin
                mem[wr_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
            end
        end
    end

endmodule

`default_nettype wire

/* src/icache_core.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_core #(
    parameter int NUM_WAYS    = 4,
    parameter int INDEX_BITS  = 2,
    parameter int OFFSET_BITS = 2
) (
    input  wire logic                   clk,
    input  wire logic                   resetn,
    input  wire icache_pkg::ibus_req_t  ibus_req,
    output icache_pkg::ibus_resp_t      ibus_resp,
    output icache_pkg::cbus_req_t       cbus_req,
    input  wire icache_pkg::cbus_resp_t cbus_resp
);
    localparam int WAY_BITS       = $clog2(NUM_WAYS);
    localparam int NUM_SETS       = 2 ** INDEX_BITS;
    localparam int ALIGN_BITS     = $clog2(icache_pkg::FETCH_BYTES);
    localparam int BUS_ALIGN_BITS = $clog2(icache_pkg::BUS_BYTES);
    localparam int SHAMT_BITS     = ALIGN_BITS - BUS_ALIGN_BITS;
    localparam int BEATS_PER_WORD = 2 ** SHAMT_BITS;
    localparam int COUNT_BITS     = OFFSET_BITS + SHAMT_BITS;
    localparam int BEATS_PER_LINE = 2 ** COUNT_BITS;
    localparam int ADDR_BITS      = $bits(icache_pkg::addr_t);
    localparam int TAG_BITS       = ADDR_BITS - INDEX_BITS - OFFSET_BITS - ALIGN_BITS;

    typedef logic [WAY_BITS-1:0]                 way_t;
    typedef logic [INDEX_BITS-1:0]               index_t;
    typedef logic [OFFSET_BITS-1:0]              offset_t;
    typedef logic [SHAMT_BITS-1:0]               shamt_t;
    typedef logic [TAG_BITS-1:0]                 tag_t;
    typedef logic [NUM_WAYS-2:0]                 select_t;
    typedef logic [BEATS_PER_LINE-1:0]           beat_mask_t;
    typedef logic [icache_pkg::FETCH_BYTES-1:0]  byte_en_t;

    // address above the beat alignment bits
    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
        shamt_t  shamt;
    } beat_addr_t;

    // beat position inside the line, wraps on its own
    typedef struct packed {
        offset_t offset;
        shamt_t  shamt;
    } count_t;

    typedef struct packed {
        way_t    way;
        index_t  index;
        offset_t offset;
    } ram_addr_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } line_t;

    typedef enum logic {
        ST_IDLE,
        ST_FILLING
    } fill_state_t;

    localparam byte_en_t BUS_MASK = byte_en_t'({icache_pkg::BUS_BYTES{1'b1}});

    // request decode and tag compare
    beat_addr_t req_addr;
    assign req_addr = beat_addr_t'(ibus_req.addr[ADDR_BITS-1:BUS_ALIGN_BITS]);

    line_t [NUM_WAYS-1:0] set_lines [NUM_SETS];
    select_t              set_select [NUM_SETS];

    line_t [NUM_WAYS-1:0] req_lines;
    logic [NUM_WAYS-1:0]  hit_bits;
    logic                 req_hit;
    way_t                 hit_way;

    assign req_lines = set_lines[req_addr.index];

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_hit
        assign hit_bits[w] = req_lines[w].valid && req_lines[w].tag == req_addr.tag;
    end

    assign req_hit = |hit_bits;

    // one-hot to way number
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit_bits[w]) begin
                hit_way = hit_way | way_t'(w);
            end
        end
    end

    way_t    victim_way;
    select_t new_select;

    plru_tree #(
        .NUM_WAYS(NUM_WAYS)
    ) plru_tree_i (
        .select    (set_select[req_addr.index]),
        .hit_way   (hit_way),
        .victim_way(victim_way),
        .new_select(new_select)
    );

    // refill engine state
    fill_state_t         fill_state;
    way_t                fill_way;
    index_t              fill_index;
    count_t              fill_count;
    beat_mask_t          fill_marks;
    beat_mask_t          fill_ready;
    icache_pkg::addr_t   fill_addr;

    beat_ready_mask #(
        .OFFSET_BITS   (OFFSET_BITS),
        .BEATS_PER_WORD(BEATS_PER_WORD)
    ) beat_ready_mask_i (
        .marks(fill_marks),
        .ready(fill_ready)
    );

    logic   fill_done;
    logic   in_fill;
    logic   word_ready;
    logic   req_ready;
    logic   accept;
    logic   miss_take;
    count_t word_last;

    assign fill_done = cbus_resp.okay && cbus_resp.last;
    assign in_fill   = fill_state == ST_FILLING && hit_way == fill_way &&
        req_addr.index == fill_index;

    // top beat of the requested word
    assign word_last  = '{offset: req_addr.offset, shamt: {SHAMT_BITS{1'b1}}};
    assign word_ready = fill_ready[word_last];
    assign req_ready  = req_hit && (!in_fill || word_ready);
    assign accept     = ibus_req.req && req_ready;
    assign miss_take  = ibus_req.req && !req_hit && (fill_state == ST_IDLE || fill_done);

    // data memory, read side follows the request, write side the refill
    ram_addr_t               rd_addr;
    ram_addr_t               wr_addr;
    byte_en_t                wr_en;
    icache_pkg::fetch_data_t wr_data;
    icache_pkg::fetch_data_t ram_data;

    assign rd_addr = '{way: hit_way, index: req_addr.index, offset: req_addr.offset};
    assign wr_addr = '{way: fill_way, index: fill_index, offset: fill_count.offset};
    assign wr_en   = cbus_resp.okay ?
        BUS_MASK << {fill_count.shamt, {BUS_ALIGN_BITS{1'b0}}} : '0;
    assign wr_data = {BEATS_PER_WORD{cbus_resp.rdata}};

    line_ram #(
        .NUM_WAYS   (NUM_WAYS),
        .INDEX_BITS (INDEX_BITS),
        .OFFSET_BITS(OFFSET_BITS)
    ) line_ram_i (
        .clk    (clk),
        .rd_addr(rd_addr),
        .rd_data(ram_data),
        .wr_en  (wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data)
    );

    // bytes written to the read address in the read cycle override the memory
    byte_en_t                byp_en;
    icache_pkg::fetch_data_t byp_data;
    icache_pkg::fetch_data_t resp_data;
    logic                    data_ok_q;
    logic                    resp_index_q;

    always_comb begin
        for (int b = 0; b < icache_pkg::FETCH_BYTES; b++) begin
            resp_data[b*8 +: 8] = byp_en[b] ? byp_data[b*8 +: 8] : ram_data[b*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            fill_state <= ST_IDLE;
            fill_marks <= '0;
            data_ok_q  <= 1'b0;
            byp_en     <= '0;
            for (int s = 0; s < NUM_SETS; s++) begin
                set_select[s] <= '0;
                for (int w = 0; w < NUM_WAYS; w++) begin
                    set_lines[s][w].valid <= 1'b0;
                end
            end
        end else begin
            data_ok_q    <= accept;
            resp_index_q <= req_addr.shamt;
            byp_en       <= (rd_addr == wr_addr) ? wr_en : '0;
            byp_data     <= wr_data;

            if (accept) begin
                set_select[req_addr.index] <= new_select;
            end

            if (cbus_resp.okay) begin
                fill_marks[fill_count] <= 1'b1;
                fill_count <= fill_count + 1'b1;
            end

            // a new miss may start on the last beat of the current one
            if (miss_take) begin
                fill_state <= ST_FILLING;
                fill_way   <= victim_way;
                fill_index <= req_addr.index;
                fill_count <= '{offset: req_addr.offset, shamt: req_addr.shamt};
                fill_marks <= '0;
                fill_addr  <= {req_addr, {BUS_ALIGN_BITS{1'b0}}};
                set_lines[req_addr.index][victim_way] <= '{valid: 1'b1, tag: req_addr.tag};
            end else if (fill_done) begin
                fill_state <= ST_IDLE;
            end
        end
    end

    assign ibus_resp.addr_ok = req_ready;
    assign ibus_resp.data_ok = data_ok_q;
    assign ibus_resp.data    = resp_data;
    assign ibus_resp.index   = resp_index_q;

    assign cbus_req.valid = fill_state == ST_FILLING;
    assign cbus_req.addr  = fill_addr;
    assign cbus_req.order = icache_pkg::cbus_order_t'(COUNT_BITS);

    a_valid_until_last: assert property (@(posedge clk) disable iff (resetn)
        cbus_req.valid && !fill_done |=> cbus_req.valid);

    a_no_okay_idle: assert property (@(posedge clk) disable iff (resetn)
        cbus_resp.okay |-> fill_state == ST_FILLING);

    // a tag is only ever placed in the victim way, never duplicated in a set
    a_hit_onehot: assert property (@(posedge clk) disable iff (resetn)
        $onehot0(hit_bits));

endmodule

`default_nettype wire

/* src/icache_top.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_top #(
    parameter int NUM_WAYS    = 4,
    parameter int INDEX_BITS  = 2,
    parameter int OFFSET_BITS = 2
) (
    input  wire logic                   clk,
    input  wire logic                   resetn,
    input  wire icache_pkg::ibus_req_t  ibus_req,
    output icache_pkg::ibus_resp_t      ibus_resp,
    output icache_pkg::cbus_req_t       cbus_req,
    input  wire icache_pkg::cbus_resp_t cbus_resp
);

    // 4 ways of 4 sets, 4 fetch words per line
    icache_core #(
        .NUM_WAYS   (NUM_WAYS),
        .INDEX_BITS (INDEX_BITS),
        .OFFSET_BITS(OFFSET_BITS)
    ) icache_core_i (
        .clk      (clk),
        .resetn   (resetn),
        .ibus_req (ibus_req),
        .ibus_resp(ibus_resp),
        .cbus_req (cbus_req),
        .cbus_resp(cbus_resp)
    );

endmodule

`default_nettype wire

/* sim/clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module clock_gen #(
    parameter int HALF_PERIOD = 10,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic resetn
);
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // reset is active while resetn is 1
    initial begin
        resetn = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b0;
    end

endmodule

`default_nettype wire

/* sim/icache_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_checker (
    input wire logic                   clk,
    input wire logic                   resetn,
    input wire icache_pkg::ibus_req_t  ibus_req,
    input wire icache_pkg::ibus_resp_t ibus_resp,
    input wire icache_pkg::cbus_req_t  cbus_req,
    input wire icache_pkg::cbus_resp_t cbus_resp
);
    localparam int BEATS_PER_LINE = 8;

    string              test_name = "none";
    int                 exp_misses;
    int                 misses;
    int                 test_errs;
    int                 err_count;
    int                 tests_run;
    int                 tests_failed;
    int                 beat_cnt;
    logic               prev_accept;
    logic               prev_valid;
    logic               prev_done;
    logic [BEATS_PER_LINE-1:0] arrived;
    icache_pkg::addr_t  pending [$];

    // memory rule, one 32-bit word per byte address
    function automatic icache_pkg::bus_data_t mem_word(input icache_pkg::addr_t a);
        return a ^ 32'h5a5a_0000;
    endfunction

    function automatic icache_pkg::fetch_data_t fetch_word(input icache_pkg::addr_t a);
        icache_pkg::addr_t base;
        base = a & ~32'h7;
        return {mem_word(base + 32'h4), mem_word(base)};
    endfunction

    task automatic note_error(input string msg);
        test_errs++;
        err_count++;
        $display("Error in %s: %s", test_name, msg);
    endtask

    task automatic begin_test(input string name, input int expected);
        test_name  = name;
        exp_misses = expected;
        misses     = 0;
        test_errs  = 0;
    endtask

    task automatic end_test();
        if (misses != exp_misses) begin
            test_errs++;
            err_count++;
            $display("Mismatch in %s: miss count expected %0d, actual %0d",
                test_name, exp_misses, misses);
        end
        if (pending.size() != 0) begin
            note_error("requests accepted without data_ok");
        end
        tests_run++;
        if (test_errs != 0) begin
            tests_failed++;
        end
        $display("test %s: %s, misses %0d", test_name, test_errs == 0 ? "ok" : "failed",
            misses);
    endtask

    task automatic report_counts();
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
    endtask

    initial begin
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        prev_accept  = 1'b0;
        prev_valid   = 1'b0;
        prev_done    = 1'b0;
    end

    always @(posedge clk) begin
        icache_pkg::addr_t a;
        logic [2:0]        slot;
        if (resetn) begin
            prev_accept = 1'b0;
            prev_valid  = 1'b0;
            prev_done   = 1'b0;
        end else begin
            // data_ok one cycle after acceptance
            if (ibus_resp.data_ok !== prev_accept) begin
                note_error("data_ok not one cycle after acceptance");
            end
            if (ibus_resp.data_ok && pending.size() > 0) begin
                a = pending.pop_front();
                if (ibus_resp.data !== fetch_word(a)) begin
                    test_errs++;
                    err_count++;
                    $display("Mismatch in %s: addr %h data expected %h, actual %h",
                        test_name, a, fetch_word(a), ibus_resp.data);
                end
                if (ibus_resp.index !== a[2]) begin
                    test_errs++;
                    err_count++;
                    $display("Mismatch in %s: addr %h index expected %0d, actual %0d",
                        test_name, a, a[2], ibus_resp.index);
                end
            end
            // new refill request
            if (cbus_req.valid && (!prev_valid || prev_done)) begin
                misses++;
                beat_cnt = 0;
                arrived  = '0;
                if (cbus_req.addr !== (ibus_req.addr & ~32'h3)) begin
                    test_errs++;
                    err_count++;
                    $display("Mismatch in %s: refill addr expected %h, actual %h",
                        test_name, ibus_req.addr & ~32'h3, cbus_req.addr);
                end
            end
            // a word of the filling line is answered once both its beats are in
            if (cbus_req.valid && ibus_req.req && !ibus_resp.addr_ok &&
                    ibus_req.addr[31:5] == cbus_req.addr[31:5] &&
                    arrived[{ibus_req.addr[4:3], 1'b0} +: 2] == 2'b11) begin
                note_error("a word of the filling line was held after its beats arrived");
            end
            if (cbus_resp.okay) begin
                // beats wrap inside the line from the requested one
                slot = cbus_req.addr[4:2] + 3'(beat_cnt);
                arrived[slot] = 1'b1;
                beat_cnt++;
                if (cbus_resp.last && beat_cnt != BEATS_PER_LINE) begin
                    note_error($sformatf("refill ended after %0d beats", beat_cnt));
                end
            end
            prev_accept = ibus_req.req && ibus_resp.addr_ok;
            if (prev_accept) begin
                pending.push_back(ibus_req.addr);
            end
            prev_valid = cbus_req.valid;
            prev_done  = cbus_resp.okay && cbus_resp.last;
        end
    end

endmodule

`default_nettype wire

/* sim/tb_icache.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_icache;
    localparam int RESET_CYCLES = 8;

    logic                   clk;
    logic                   resetn;
    icache_pkg::ibus_req_t  ibus_req;
    icache_pkg::ibus_resp_t ibus_resp;
    icache_pkg::cbus_req_t  cbus_req;
    icache_pkg::cbus_resp_t cbus_resp;

    string             names [$];
    int                exp_counts [$];
    int                addr_counts [$];
    icache_pkg::addr_t addrs [$];
    bit                loaded = 1'b0;

    // burst memory state
    bit                mem_busy = 1'b0;
    bit                just_done = 1'b0;
    int                beat_n;
    int                burst_beats;
    int                gap;
    icache_pkg::addr_t start_addr;

    clock_gen #(.RESET_CYCLES(RESET_CYCLES)) clock_gen_i (.clk(clk), .resetn(resetn));

    icache_top icache_top_i (
        .clk(clk), .resetn(resetn), .ibus_req(ibus_req), .ibus_resp(ibus_resp),
        .cbus_req(cbus_req), .cbus_resp(cbus_resp)
    );

    icache_checker checker_i (
        .clk(clk), .resetn(resetn), .ibus_req(ibus_req), .ibus_resp(ibus_resp),
        .cbus_req(cbus_req), .cbus_resp(cbus_resp)
    );

    // beats wrap inside the burst from the critical one
    function automatic icache_pkg::addr_t wrap_addr(input icache_pkg::addr_t a, input int n,
        input int beats);
        icache_pkg::addr_t span;
        span = 4 * beats;
        return (a & ~(span - 1)) | ((a + 4 * n) & (span - 1));
    endfunction

    always @(posedge clk) begin
        if (resetn) begin
            mem_busy = 1'b0;
            cbus_resp <= '0;
        end else begin
            just_done = 1'b0;
            if (cbus_resp.okay) begin
                beat_n++;
                if (cbus_resp.last) begin
                    mem_busy  = 1'b0;
                    just_done = 1'b1;
                end
            end
            if (mem_busy && gap > 0) begin
                gap--;
                cbus_resp <= '0;
            end else if (mem_busy) begin
                cbus_resp <= '{okay: 1'b1, last: beat_n == burst_beats - 1,
                    rdata: wrap_addr(start_addr, beat_n, burst_beats) ^ 32'h5a5a_0000};
                gap = $urandom % 4;
            end else begin
                cbus_resp <= '0;
                // valid still reflects the old burst in the cycle after its last beat
                if (!just_done && cbus_req.valid) begin
                    mem_busy    = 1'b1;
                    start_addr  = cbus_req.addr;
                    // burst length from the order field
                    burst_beats = 1 << cbus_req.order;
                    beat_n      = 0;
                    gap         = $urandom % 4;
                end
            end
        end
    end

    task automatic load_vectors(output bit ok);
        int                fd;
        int                n;
        int                e;
        int                c;
        string             tok;
        string             rest;
        icache_pkg::addr_t a;
        fd = $fopen("sim/icache_vectors.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                n = $fscanf(fd, "%s", tok);
                if (n != 1) break;
                if (tok.getc(0) == 8'h23) begin
                    n = $fgets(rest, fd);
                    continue;
                end
                n = $fscanf(fd, "%d %d", e, c);
                names.push_back(tok);
                exp_counts.push_back(e);
                addr_counts.push_back(c);
                for (int k = 0; k < c; k++) begin
                    n = $fscanf(fd, "%h", a);
                    addrs.push_back(a);
                end
            end
            $fclose(fd);
        end
    endtask

    // watchdog, 400 cycles per vector line
    initial begin
        wait (loaded);
        repeat (RESET_CYCLES + 400 * names.size()) @(posedge clk);
        $display("watchdog expired, the run did not finish in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        int pos;
        bit opened;
        ibus_req = '0;
        cbus_resp = '0;
        void'($urandom(32'hc7239394));
        load_vectors(opened);
        if (!opened) begin
            $display("cannot open the vectors file");
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            loaded = 1'b1;
            wait (!resetn);
            repeat (2) @(posedge clk);
            pos = 0;
            for (int t = 0; t < names.size(); t++) begin
                checker_i.begin_test(names[t], exp_counts[t]);
                for (int k = 0; k < addr_counts[t]; k++) begin
                    ibus_req <= '{req: 1'b1, addr: addrs[pos]};
                    pos++;
                    @(posedge clk);
                    while (!ibus_resp.addr_ok) @(posedge clk);
                end
                ibus_req <= '0;
                @(posedge clk);
                while (cbus_req.valid) @(posedge clk);
                repeat (2) @(posedge clk);
                checker_i.end_test();
            end
            checker_i.report_counts();
            if (checker_i.err_count == 0) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* src.f */
src/icache_pkg.sv
src/plru_tree.sv
src/beat_ready_mask.sv
src/line_ram.sv
src/icache_core.sv
src/icache_top.sv
sim/clock_gen.sv
sim/icache_checker.sv
sim/tb_icache.sv

/* Makefile */
# Verilator build and run for the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= tb_icache
BUILD_DIR ?= obj_dir
FILE_LIST ?= src.f
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

$(BUILD_DIR)/V$(TOP): $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* sim/icache_vectors.txt */
# columns: test name, expected refill count, number of addresses, then the addresses in hex
# memory beat at byte address a is a xor 5a5a0000
first_miss 1 1 00001004
repeat_hits 0 5 00001000 00001008 00001010 00001018 00001004
critical_wrap 1 4 00002014 00002000 00002008 0000201c
early_word 1 4 00003000 00003008 00003010 00003018
plru_set3 6 11 00005060 00005160 00005260 00005360 00005060 00005160 00005460 00005060 00005160 00005260 00005360
